// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////
   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int reg_count  = 1 << reg_addr_w;
   localparam int shamt_w    = $clog2(xlen);
   localparam int op_w       = 4;

   typedef logic [xlen-1:0]       data_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;

   //////////////////////////////
   // unit classes and op codes
   //////////////////////////////
   typedef enum logic [1:0] {
      unit_alu = 2'd0,
      unit_mul = 2'd1,
      unit_lsu = 2'd2
   } unit_e;

   // alu_lui passes operand b through
   typedef enum logic [op_w-1:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_slt  = 4'd5,
      alu_sltu = 4'd6,
      alu_sll  = 4'd7,
      alu_srl  = 4'd8,
      alu_sra  = 4'd9,
      alu_lui  = 4'd10
   } alu_op_e;

   typedef enum logic [1:0] {
      mul_lo = 2'd0,
      mul_hs = 2'd1,
      mul_hu = 2'd2
   } mul_op_e;

   typedef enum logic {
      lsu_load  = 1'b0,
      lsu_store = 1'b1
   } lsu_op_e;

endpackage

`default_nettype wire

// ==== rtl/exu_dispatch.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_dispatch (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       issue_valid,
   input  exu_pkg::unit_e             issue_unit,
   input  logic [exu_pkg::op_w-1:0]   issue_op,
   input  exu_pkg::reg_addr_t         issue_rd,
   input  exu_pkg::reg_addr_t         issue_rs1,
   input  exu_pkg::reg_addr_t         issue_rs2,
   input  exu_pkg::data_t             issue_imm,
   input  logic                       issue_use_imm,
   input  logic                       issue_wen,
   input  exu_pkg::data_t             rf_rs1_data,
   input  exu_pkg::data_t             rf_rs2_data,
   output exu_pkg::reg_addr_t         rf_rs1,
   output exu_pkg::reg_addr_t         rf_rs2,
   input  logic                       lsu_finish,
   output logic                       stall,
   output logic                       alu_valid_e,
   output logic                       mul_valid_e,
   output logic                       lsu_valid,
   output logic [exu_pkg::op_w-1:0]   op_e,
   output exu_pkg::reg_addr_t         rd_e,
   output logic                       wen_e,
   output exu_pkg::reg_addr_t         rs1_e,
   output exu_pkg::reg_addr_t         rs2_e,
   output logic                       use_imm_e,
   output exu_pkg::data_t             a_e,
   output exu_pkg::data_t             b_e,
   output exu_pkg::data_t             imm_e
);
   import exu_pkg::*;

   logic  alu_disp_d;
   logic  mul_disp_d;
   logic  lsu_disp_d;
   logic  mem_pend;
   data_t b_d;

   // per-unit dispatch from the class field
   assign alu_disp_d = issue_valid & (issue_unit == unit_alu);
   assign mul_disp_d = issue_valid & (issue_unit == unit_mul);
   assign lsu_disp_d = issue_valid & (issue_unit == unit_lsu);

   assign rf_rs1 = issue_rs1;
   assign rf_rs2 = issue_rs2;

   // immediate replaces rs2
   assign b_d = issue_use_imm ? issue_imm : rf_rs2_data;

   //////////////////////////////
   // D to E
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         alu_valid_e <= 1'b0;
         mul_valid_e <= 1'b0;
         lsu_valid   <= 1'b0;
         wen_e       <= 1'b0;
      end else begin
         alu_valid_e <= alu_disp_d;
         mul_valid_e <= mul_disp_d;
         lsu_valid   <= lsu_disp_d;
         wen_e       <= issue_valid & issue_wen;
      end
   end

   always_ff @(posedge clk) begin
      op_e      <= issue_op;
      rd_e      <= issue_rd;
      rs1_e     <= issue_rs1;
      rs2_e     <= issue_rs2;
      use_imm_e <= issue_use_imm;
      a_e       <= rf_rs1_data;
      b_e       <= b_d;
      imm_e     <= issue_imm;
   end

   // outstanding memory op, held until the lsu reports back
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_pend <= 1'b0;
      end else begin
         mem_pend <= lsu_disp_d | (mem_pend & ~lsu_finish);
      end
   end

   // raised in the issue cycle itself, dropped after finish
   assign stall = mem_pend | lsu_disp_d;

endmodule

`default_nettype wire

// ==== rtl/exu_bypass.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_bypass (
   input  exu_pkg::reg_addr_t rs1_e,
   input  exu_pkg::reg_addr_t rs2_e,
   input  logic               use_imm_e,
   input  exu_pkg::data_t     a_e,
   input  exu_pkg::data_t     b_e,
   input  exu_pkg::reg_addr_t m_rd,
   input  logic               m_wen,
   input  exu_pkg::data_t     m_data,
   input  exu_pkg::reg_addr_t wb_rd,
   input  logic               wb_wen,
   input  exu_pkg::data_t     wb_data,
   output exu_pkg::data_t     op_a,
   output exu_pkg::data_t     op_b
);

   logic m_live;
   logic w_live;
   logic a_hit_m;
   logic a_hit_w;
   logic b_hit_m;
   logic b_hit_w;

   // x0 never forwards
   assign m_live = m_wen & (m_rd != '0);
   assign w_live = wb_wen & (wb_rd != '0);

   assign a_hit_m = m_live & (m_rd == rs1_e);
   assign a_hit_w = w_live & (wb_rd == rs1_e);

   // b holds the immediate when use_imm is set
   assign b_hit_m = ~use_imm_e & m_live & (m_rd == rs2_e);
   assign b_hit_w = ~use_imm_e & w_live & (wb_rd == rs2_e);

   // younger result wins
   assign op_a = a_hit_m ? m_data :
                 a_hit_w ? wb_data : a_e;
   assign op_b = b_hit_m ? m_data :
                 b_hit_w ? wb_data : b_e;

endmodule

`default_nettype wire

// ==== rtl/exu_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_alu (
   input  logic                     clk,
   input  exu_pkg::data_t           op_a,
   input  exu_pkg::data_t           op_b,
   input  logic [exu_pkg::op_w-1:0] op_e,
   output exu_pkg::data_t           alu_res_m
);
   import exu_pkg::*;

   alu_op_e            op;
   logic [shamt_w-1:0] shamt;
   data_t              res;

   assign op    = alu_op_e'(op_e);
   assign shamt = op_b[shamt_w-1:0];

   always_comb begin
      case (op)
         alu_add:  res = op_a + op_b;
         alu_sub:  res = op_a - op_b;
         alu_and:  res = op_a & op_b;
         alu_or:   res = op_a | op_b;
         alu_xor:  res = op_a ^ op_b;
         alu_slt: begin
            res = {{(xlen-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
         end
         alu_sltu: begin
            res = {{(xlen-1){1'b0}}, (op_a < op_b)};
         end
         alu_sll:  res = op_a << shamt;
         alu_srl:  res = op_a >> shamt;
         // arithmetic shift keeps the sign
         alu_sra:  res = data_t'($signed(op_a) >>> shamt);
         alu_lui:  res = op_b;
         default:  res = '0;
      endcase
   end

   //////////////////////////////
   // E to M
   //////////////////////////////
   always_ff @(posedge clk) begin
      alu_res_m <= res;
   end

endmodule

`default_nettype wire

// ==== rtl/exu_mul.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_mul (
   input  logic                     clk,
   input  exu_pkg::data_t           op_a,
   input  exu_pkg::data_t           op_b,
   input  logic [exu_pkg::op_w-1:0] op_e,
   output exu_pkg::data_t           mul_res_m
);
   import exu_pkg::*;

   mul_op_e                  op;
   logic                     sgn;
   logic signed [xlen:0]     a_x;
   logic signed [xlen:0]     b_x;
   logic signed [2*xlen+1:0] prod;
   data_t                    res;

   assign op  = mul_op_e'(op_e[1:0]);
   assign sgn = (op == mul_hs);

   // one 33x33 signed multiplier covers both signed and unsigned
   assign a_x  = {sgn & op_a[xlen-1], op_a};
   assign b_x  = {sgn & op_b[xlen-1], op_b};
   assign prod = a_x * b_x;

   // low half is the same either way
   assign res = (op == mul_lo) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];

   always_ff @(posedge clk) begin
      mul_res_m <= res;
   end

endmodule

`default_nettype wire

// ==== rtl/exu_wb_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_wb_arbiter (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               alu_valid_e,
   input  logic               mul_valid_e,
   input  exu_pkg::reg_addr_t rd_e,
   input  logic               wen_e,
   input  exu_pkg::data_t     alu_res_m,
   input  exu_pkg::data_t     mul_res_m,
   input  logic               lsu_finish,
   input  exu_pkg::data_t     lsu_rdata,
   input  exu_pkg::reg_addr_t lsu_fin_rd,
   input  logic               lsu_fin_wen,
   output exu_pkg::reg_addr_t m_rd,
   output logic               m_wen,
   output exu_pkg::data_t     m_data,
   output logic               wb_wen,
   output exu_pkg::reg_addr_t wb_rd,
   output exu_pkg::data_t     wb_data
);
   import exu_pkg::*;

   reg_addr_t rd_q;
   logic      alu_wen_m;
   logic      mul_wen_m;
   logic      mul_sel_m;
   logic      lsu_claim;

   //////////////////////////////
   // E to M
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         alu_wen_m <= 1'b0;
         mul_wen_m <= 1'b0;
         mul_sel_m <= 1'b0;
      end else begin
         alu_wen_m <= alu_valid_e & wen_e;
         mul_wen_m <= mul_valid_e & wen_e;
         mul_sel_m <= mul_valid_e;
      end
   end

   always_ff @(posedge clk) begin
      rd_q <= rd_e;
   end

   // a store finishes without a claim
   assign lsu_claim = lsu_finish & lsu_fin_wen;

   // lsu first, then mul, alu by default
   always_comb begin
      if (lsu_claim) begin
         m_rd   = lsu_fin_rd;
         m_data = lsu_rdata;
      end else if (mul_sel_m) begin
         m_rd   = rd_q;
         m_data = mul_res_m;
      end else begin
         m_rd   = rd_q;
         m_data = alu_res_m;
      end
   end

   assign m_wen = lsu_claim | alu_wen_m | mul_wen_m;

   //////////////////////////////
   // M to W
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_wen <= 1'b0;
      end else begin
         wb_wen <= m_wen;
      end
   end

   always_ff @(posedge clk) begin
      wb_rd   <= m_rd;
      wb_data <= m_data;
   end

endmodule

`default_nettype wire

// ==== rtl/exu_regfile.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_regfile (
   input  logic               clk,
   input  exu_pkg::reg_addr_t rf_rs1,
   input  exu_pkg::reg_addr_t rf_rs2,
   input  logic               wb_wen,
   input  exu_pkg::reg_addr_t wb_rd,
   input  exu_pkg::data_t     wb_data,
   output exu_pkg::data_t     rf_rs1_data,
   output exu_pkg::data_t     rf_rs2_data
);
   import exu_pkg::*;

   data_t regs [reg_count];
   logic  wr_live;

   // writes to x0 are dropped
   assign wr_live = wb_wen & (wb_rd != '0);

   always_ff @(posedge clk) begin
      if (wr_live) begin
         regs[wb_rd] <= wb_data;
      end
   end

   // x0 reads zero, a same-cycle write shows through
   assign rf_rs1_data = (rf_rs1 == '0)                  ? '0      :
                        (wr_live && (wb_rd == rf_rs1)) ? wb_data : regs[rf_rs1];
   assign rf_rs2_data = (rf_rs2 == '0)                  ? '0      :
                        (wr_live && (wb_rd == rf_rs2)) ? wb_data : regs[rf_rs2];

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_top (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     issue_valid,
   input  exu_pkg::unit_e           issue_unit,
   input  logic [exu_pkg::op_w-1:0] issue_op,
   input  exu_pkg::reg_addr_t       issue_rd,
   input  exu_pkg::reg_addr_t       issue_rs1,
   input  exu_pkg::reg_addr_t       issue_rs2,
   input  exu_pkg::data_t           issue_imm,
   input  logic                     issue_use_imm,
   input  logic                     issue_wen,
   output logic                     stall,
   output logic                     lsu_valid,
   output exu_pkg::lsu_op_e         lsu_op,
   output exu_pkg::data_t           lsu_base,
   output exu_pkg::data_t           lsu_offset,
   output exu_pkg::data_t           lsu_wdata,
   output exu_pkg::reg_addr_t       lsu_rd,
   output logic                     lsu_wen,
   input  logic                     lsu_finish,
   input  exu_pkg::data_t           lsu_rdata,
   input  exu_pkg::reg_addr_t       lsu_fin_rd,
   input  logic                     lsu_fin_wen,
   output logic                     wb_wen,
   output exu_pkg::reg_addr_t       wb_rd,
   output exu_pkg::data_t           wb_data
);
   import exu_pkg::*;

   reg_addr_t        rf_rs1;
   reg_addr_t        rf_rs2;
   data_t            rf_rs1_data;
   data_t            rf_rs2_data;
   logic             alu_valid_e;
   logic             mul_valid_e;
   logic [op_w-1:0]  op_e;
   reg_addr_t        rd_e;
   logic             wen_e;
   reg_addr_t        rs1_e;
   reg_addr_t        rs2_e;
   logic             use_imm_e;
   data_t            a_e;
   data_t            b_e;
   data_t            imm_e;
   data_t            op_a;
   data_t            op_b;
   data_t            alu_res_m;
   data_t            mul_res_m;
   reg_addr_t        m_rd;
   logic             m_wen;
   data_t            m_data;

   // lsu request at E takes the bypassed operands
   assign lsu_op     = lsu_op_e'(op_e[0]);
   assign lsu_base   = op_a;
   assign lsu_offset = imm_e;
   assign lsu_wdata  = op_b;
   assign lsu_rd     = rd_e;
   assign lsu_wen    = wen_e;

   exu_dispatch u_dispatch (
      .clk           (clk),
      .arst_n        (arst_n),
      .issue_valid   (issue_valid),
      .issue_unit    (issue_unit),
      .issue_op      (issue_op),
      .issue_rd      (issue_rd),
      .issue_rs1     (issue_rs1),
      .issue_rs2     (issue_rs2),
      .issue_imm     (issue_imm),
      .issue_use_imm (issue_use_imm),
      .issue_wen     (issue_wen),
      .rf_rs1_data   (rf_rs1_data),
      .rf_rs2_data   (rf_rs2_data),
      .rf_rs1        (rf_rs1),
      .rf_rs2        (rf_rs2),
      .lsu_finish    (lsu_finish),
      .stall         (stall),
      .alu_valid_e   (alu_valid_e),
      .mul_valid_e   (mul_valid_e),
      .lsu_valid     (lsu_valid),
      .op_e          (op_e),
      .rd_e          (rd_e),
      .wen_e         (wen_e),
      .rs1_e         (rs1_e),
      .rs2_e         (rs2_e),
      .use_imm_e     (use_imm_e),
      .a_e           (a_e),
      .b_e           (b_e),
      .imm_e         (imm_e)
   );

   exu_bypass u_bypass (
      .rs1_e     (rs1_e),
      .rs2_e     (rs2_e),
      .use_imm_e (use_imm_e),
      .a_e       (a_e),
      .b_e       (b_e),
      .m_rd      (m_rd),
      .m_wen     (m_wen),
      .m_data    (m_data),
      .wb_rd     (wb_rd),
      .wb_wen    (wb_wen),
      .wb_data   (wb_data),
      .op_a      (op_a),
      .op_b      (op_b)
   );

   exu_alu u_alu (
      .clk       (clk),
      .op_a      (op_a),
      .op_b      (op_b),
      .op_e      (op_e),
      .alu_res_m (alu_res_m)
   );

   exu_mul u_mul (
      .clk       (clk),
      .op_a      (op_a),
      .op_b      (op_b),
      .op_e      (op_e),
      .mul_res_m (mul_res_m)
   );

   exu_wb_arbiter u_wb_arbiter (
      .clk         (clk),
      .arst_n      (arst_n),
      .alu_valid_e (alu_valid_e),
      .mul_valid_e (mul_valid_e),
      .rd_e        (rd_e),
      .wen_e       (wen_e),
      .alu_res_m   (alu_res_m),
      .mul_res_m   (mul_res_m),
      .lsu_finish  (lsu_finish),
      .lsu_rdata   (lsu_rdata),
      .lsu_fin_rd  (lsu_fin_rd),
      .lsu_fin_wen (lsu_fin_wen),
      .m_rd        (m_rd),
      .m_wen       (m_wen),
      .m_data      (m_data),
      .wb_wen      (wb_wen),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data)
   );

   exu_regfile u_regfile (
      .clk         (clk),
      .rf_rs1      (rf_rs1),
      .rf_rs2      (rf_rs2),
      .wb_wen      (wb_wen),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data),
      .rf_rs1_data (rf_rs1_data),
      .rf_rs2_data (rf_rs2_data)
   );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   // 40 ns period
   localparam int half_period = 20;

   initial begin
      clk = 1'b0;
      forever begin
         #(half_period) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

// ==== tests/exu_props.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_props (
   input logic clk,
   input logic arst_n,
   input logic issue_valid,
   input logic lsu_finish,
   input logic stall,
   input logic wb_wen
);

   // held from a memory issue until the unit reports back
   a_stall_held: assert property (@(posedge clk) disable iff (!arst_n)
      (stall && !lsu_finish) |=> stall)
      else $error("stall dropped before lsu_finish");

   a_wb_after_reset: assert property (@(posedge clk)
      $rose(arst_n) |-> !wb_wen)
      else $error("wb_wen high in the first cycle after reset");

   // pending memory op blocks the issuer
   a_no_issue_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
      (stall && !lsu_finish) |=> !issue_valid)
      else $error("issue strobe while stall was high");

endmodule

`default_nettype wire

// ==== tests/exu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module exu_tb;
   import exu_pkg::*;

   localparam int drive_delay = 5;
   // reset, then the six tests, each rounded up
   localparam int est_cycles = 10 + 10 + 40 + 60 + 30 + 50 + 100;
   localparam int timeout_cycles = 10 * est_cycles;

   logic            clk;
   logic            arst_n;
   logic            issue_valid;
   unit_e           issue_unit;
   logic [op_w-1:0] issue_op;
   reg_addr_t       issue_rd;
   reg_addr_t       issue_rs1;
   reg_addr_t       issue_rs2;
   data_t           issue_imm;
   logic            issue_use_imm;
   logic            issue_wen;
   logic            stall;
   logic            lsu_valid;
   lsu_op_e         lsu_op;
   data_t           lsu_base;
   data_t           lsu_offset;
   data_t           lsu_wdata;
   reg_addr_t       lsu_rd;
   logic            lsu_wen;
   logic            lsu_finish;
   data_t           lsu_rdata;
   reg_addr_t       lsu_fin_rd;
   logic            lsu_fin_wen;
   logic            wb_wen;
   reg_addr_t       wb_rd;
   data_t           wb_data;

   int          cycle = 0;
   int          errors;
   int          checks;
   int          test_errs;
   int          tests_run;
   int          tests_failed;
   string       test_name;
   logic [31:0] lfsr;

   // reference state
   data_t     model_regs [reg_count];
   data_t     mem [data_t];
   int        exp_cyc [$];
   reg_addr_t exp_rd [$];
   data_t     exp_data [$];

   tb_clock u_clock (
      .clk (clk)
   );

   exu_top u_exu_top (.*);

   bind exu_top exu_props u_props (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue_valid (issue_valid),
      .lsu_finish  (lsu_finish),
      .stall       (stall),
      .wb_wen      (wb_wen)
   );

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= timeout_cycles) begin
         $display("run timed out after %0d cycles, the DUT stopped responding", cycle);
         $display("TEST FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // reference models
   //////////////////////////////

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic data_t alu_model(alu_op_e op, data_t a, data_t b);
      int unsigned sh;
      sh = b % 32;
      case (op)
         alu_add:  return a + b;
         alu_sub:  return a + ~b + 1;
         alu_and:  return a & b;
         alu_or:   return a | b;
         alu_xor:  return a ^ b;
         // differing signs decide on their own
         alu_slt:  return (a[31] != b[31]) ? data_t'(a[31]) : data_t'(a < b);
         alu_sltu: return data_t'(a < b);
         alu_sll:  return a << sh;
         alu_srl:  return a >> sh;
         alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
         alu_lui:  return b;
         default:  return 32'h0;
      endcase
   endfunction

   function automatic data_t mul_model(mul_op_e op, data_t a, data_t b);
      logic [63:0]        pu;
      logic signed [63:0] ps;
      pu = {32'h0, a} * {32'h0, b};
      ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      case (op)
         mul_lo:  return pu[31:0];
         mul_hs:  return ps[63:32];
         default: return pu[63:32];
      endcase
   endfunction

   // untouched words read a pattern of the address
   function automatic data_t mem_read(data_t addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
   endfunction

   //////////////////////////////
   // helpers
   //////////////////////////////
   task automatic check(string what, logic [31:0] exp, logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         test_errs++;
         $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   // advance one cycle, then compare wb_* with the oldest expectation
   task automatic next_cycle();
      @(posedge clk);
      #(drive_delay);
      if (exp_cyc.size() != 0 && exp_cyc[0] == cycle) begin
         check("wb_wen", 1, wb_wen);
         check("wb_rd", exp_rd[0], wb_rd);
         check("wb_data", exp_data[0], wb_data);
         void'(exp_cyc.pop_front());
         void'(exp_rd.pop_front());
         void'(exp_data.pop_front());
      end else begin
         check("unexpected wb_wen", 0, wb_wen);
      end
      issue_valid = 1'b0;
      lsu_finish  = 1'b0;
      lsu_fin_wen = 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_cyc.size() != 0 && n < 8) begin
         next_cycle();
         n++;
      end
      if (exp_cyc.size() != 0) begin
         errors++;
         test_errs++;
         $display("%s: %0d writebacks never arrived", test_name, exp_cyc.size());
         exp_cyc.delete();
         exp_rd.delete();
         exp_data.delete();
      end
   endtask

   task automatic issue(unit_e unit, logic [op_w-1:0] op, int rd, int rs1, int rs2,
                        data_t imm, logic use_imm);
      data_t a;
      data_t b;
      data_t res;
      a = model_regs[rs1];
      b = use_imm ? imm : model_regs[rs2];
      if (unit == unit_mul) begin
         res = mul_model(mul_op_e'(op[1:0]), a, b);
      end else begin
         res = alu_model(alu_op_e'(op), a, b);
      end
      check("stall before issue", 0, stall);
      if (rd != 0) begin
         model_regs[rd] = res;
      end
      exp_cyc.push_back(cycle + 3);
      exp_rd.push_back(reg_addr_t'(rd));
      exp_data.push_back(res);
      issue_valid   = 1'b1;
      issue_unit    = unit;
      issue_op      = op;
      issue_rd      = reg_addr_t'(rd);
      issue_rs1     = reg_addr_t'(rs1);
      issue_rs2     = reg_addr_t'(rs2);
      issue_imm     = imm;
      issue_use_imm = use_imm;
      issue_wen     = 1'b1;
      next_cycle();
   endtask

   task automatic alu(alu_op_e op, int rd, int rs1, int rs2);
      issue(unit_alu, op, rd, rs1, rs2, '0, 1'b0);
   endtask

   task automatic mul(mul_op_e op, int rd, int rs1, int rs2);
      issue(unit_mul, {2'b00, op}, rd, rs1, rs2, '0, 1'b0);
   endtask

   task automatic set_reg(int rd, data_t value);
      issue(unit_alu, alu_lui, rd, 0, 0, value, 1'b1);
   endtask

   // issue a load or store and play the load/store unit
   task automatic mem_op(lsu_op_e op, int rd, int rs1, int rs2, data_t imm);
      data_t     addr;
      data_t     value;
      data_t     req_addr;
      reg_addr_t req_rd;
      int        lat;
      addr = model_regs[rs1] + imm;
      lat  = int'(rand_bits(3) % 6) + 1;
      check("stall before issue", 0, stall);
      issue_valid   = 1'b1;
      issue_unit    = unit_lsu;
      issue_op      = {3'b000, op};
      issue_rd      = reg_addr_t'(rd);
      issue_rs1     = reg_addr_t'(rs1);
      issue_rs2     = reg_addr_t'(rs2);
      issue_imm     = imm;
      issue_use_imm = 1'b0;
      issue_wen     = (op == lsu_load);
      #1;
      check("stall in issue cycle", 1, stall);
      next_cycle();
      check("lsu_valid", 1, lsu_valid);
      check("lsu_op", op, lsu_op);
      check("lsu_base", model_regs[rs1], lsu_base);
      check("lsu_offset", imm, lsu_offset);
      check("lsu_rd", rd, lsu_rd);
      check("lsu_wen", op == lsu_load, lsu_wen);
      if (op == lsu_store) begin
         check("lsu_wdata", model_regs[rs2], lsu_wdata);
      end
      req_addr = lsu_base + lsu_offset;
      req_rd   = lsu_rd;
      repeat (lat) begin
         next_cycle();
         check("stall while pending", 1, stall);
         check("lsu_valid after request", 0, lsu_valid);
      end
      lsu_finish  = 1'b1;
      lsu_fin_rd  = req_rd;
      lsu_fin_wen = (op == lsu_load);
      if (op == lsu_store) begin
         mem[addr] = model_regs[rs2];
         lsu_rdata = '0;
      end else begin
         value     = mem_read(addr);
         lsu_rdata = mem_read(req_addr);
         if (rd != 0) begin
            model_regs[rd] = value;
         end
         // written back the cycle after finish
         exp_cyc.push_back(cycle + 1);
         exp_rd.push_back(reg_addr_t'(rd));
         exp_data.push_back(value);
      end
      #1;
      check("stall in finish cycle", 1, stall);
      next_cycle();
      check("stall after finish", 0, stall);
   endtask

   task automatic start_test(string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("%s: ok", test_name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", test_name, test_errs);
      end
   endtask

   //////////////////////////////
   // tests
   //////////////////////////////
   task automatic test_reset();
      start_test("reset");
      repeat (4) begin
         check("wb_wen", 0, wb_wen);
         check("stall", 0, stall);
         check("lsu_valid", 0, lsu_valid);
         next_cycle();
      end
      end_test();
   endtask

   task automatic test_alu_ops();
      start_test("alu_ops");
      for (int i = 1; i <= 8; i++) begin
         set_reg(i, rand_bits(32));
      end
      drain();
      for (int k = 0; k <= 10; k++) begin
         alu(alu_op_e'(k), 10 + k, 1 + k % 4, 5 + k % 4);
      end
      drain();
      end_test();
   endtask

   // consumer at distance 1 reads M, 2 reads W, 3 reads through the regfile
   task automatic test_bypass();
      start_test("bypass");
      for (int d = 1; d <= 3; d++) begin
         set_reg(21, rand_bits(32));
         repeat (d - 1) alu(alu_xor, 26, 3, 4);
         alu(alu_sub, 22, 21, 3);
         set_reg(23, rand_bits(32));
         repeat (d - 1) alu(alu_or, 26, 3, 4);
         alu(alu_and, 24, 7, 23);
      end
      set_reg(25, rand_bits(32));
      repeat (4) alu(alu_add, 25, 25, 21);
      drain();
      end_test();
   endtask

   task automatic test_imm();
      start_test("imm");
      for (int d = 1; d <= 3; d++) begin
         set_reg(27, rand_bits(32));
         repeat (d - 1) alu(alu_xor, 26, 3, 4);
         issue(unit_alu, alu_add, 28, 2, 27, rand_bits(32), 1'b1);
      end
      drain();
      end_test();
   endtask

   task automatic test_mul();
      start_test("mul");
      set_reg(5, 32'hffff_ffff);
      set_reg(6, 32'h8000_0000);
      set_reg(7, rand_bits(32));
      set_reg(8, rand_bits(32));
      drain();
      for (int k = 0; k < 3; k++) begin
         mul(mul_op_e'(k), 10 + k, 7, 8);
         mul(mul_op_e'(k), 13 + k, 5, 6);
         mul(mul_op_e'(k), 16 + k, 6, 6);
      end
      // back to back, each reading the one before
      mul(mul_lo, 19, 7, 8);
      mul(mul_hs, 20, 19, 5);
      mul(mul_hu, 21, 20, 19);
      mul(mul_lo, 22, 21, 21);
      drain();
      end_test();
   endtask

   task automatic test_mem();
      start_test("mem");
      set_reg(9, 32'h0000_1000 | (rand_bits(8) << 2));
      set_reg(1, rand_bits(32));
      set_reg(2, rand_bits(32));
      drain();
      mem_op(lsu_store, 0, 9, 2, 32'h8);
      mem_op(lsu_load, 11, 9, 0, 32'h8);
      alu(alu_add, 12, 11, 1);
      mem_op(lsu_load, 13, 9, 0, 32'h40);
      alu(alu_xor, 14, 1, 13);
      // store data and base still in flight
      alu(alu_xor, 15, 1, 2);
      mem_op(lsu_store, 0, 9, 15, 32'hc);
      mem_op(lsu_load, 16, 9, 0, 32'hc);
      alu(alu_add, 17, 9, 0);
      mem_op(lsu_load, 18, 17, 0, 32'h8);
      alu(alu_sub, 19, 18, 16);
      drain();
      end_test();
   endtask

   initial begin
      lfsr          = 32'hd66c4cca;
      errors        = 0;
      checks        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      model_regs[0] = '0;
      arst_n        = 1'b0;
      issue_valid   = 1'b0;
      issue_unit    = unit_alu;
      issue_op      = '0;
      issue_rd      = '0;
      issue_rs1     = '0;
      issue_rs2     = '0;
      issue_imm     = '0;
      issue_use_imm = 1'b0;
      issue_wen     = 1'b0;
      lsu_finish    = 1'b0;
      lsu_rdata     = '0;
      lsu_fin_rd    = '0;
      lsu_fin_wen   = 1'b0;
      repeat (10) @(posedge clk);
      #(drive_delay);
      arst_n = 1'b1;
      test_reset();
      test_alu_ops();
      test_bypass();
      test_imm();
      test_mul();
      test_mem();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/exu_pkg.sv
rtl/exu_dispatch.sv
rtl/exu_bypass.sv
rtl/exu_alu.sv
rtl/exu_mul.sv
rtl/exu_wb_arbiter.sv
rtl/exu_regfile.sv
rtl/exu_top.sv
tests/tb_clock.sv
tests/exu_props.sv
tests/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the exu testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
      --top-module exu_tb -Mdir obj_dir -f list.f; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/Vexu_tb > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log

if grep -qx "TEST PASS" sim.log; then
   echo "simulation passed"
   exit 0
fi

echo "simulation failed"
exit 1
